// File: logic/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module branch_unit (
    input  wire spu_odd_pkg::issue_t      iss,
    output spu_odd_pkg::fw_packet_t       pkt,
    output logic                          taken,
    output spu_odd_pkg::pc_t              target
);

    spu_odd_pkg::pc_t offset;
    spu_odd_pkg::pc_t relative;
    spu_odd_pkg::pc_t aligned;
    logic             link;

    // word offset, sign extended
    assign offset = {{(`PC_BITS - `IMM16_BITS - 2){iss.i16[0]}}, iss.i16, 2'b00};
    assign relative = iss.pc + offset;
    assign aligned = {relative[0:`PC_BITS-3], 2'b00};

    always_comb
    begin
        taken = 1'b0;
        target = '0;
        link = 1'b0;
        case (iss.op)
            spu_odd_pkg::BRANCH_RELATIVE:
            begin
                taken = 1'b1;
                target = relative;
            end
            spu_odd_pkg::BRANCH_ABSOLUTE:
            begin
                taken = 1'b1;
                target = offset;
            end
            spu_odd_pkg::BRANCH_RELATIVE_AND_SET_LINK:
            begin
                taken = 1'b1;
                link = 1'b1;
                target = relative;
            end
            spu_odd_pkg::BRANCH_ABSOLUTE_AND_SET_LINK:
            begin
                taken = 1'b1;
                link = 1'b1;
                target = offset;
            end
            // conditional forms test the preferred slot of rb
            spu_odd_pkg::BRANCH_IF_NOT_ZERO_WORD:
                taken = (iss.rb[0:31] != '0);
            spu_odd_pkg::BRANCH_IF_ZERO_WORD:
                taken = (iss.rb[0:31] == '0);
            spu_odd_pkg::BRANCH_IF_NOT_ZERO_HALFWORD:
                taken = (iss.rb[16:31] != '0);
            spu_odd_pkg::BRANCH_IF_ZERO_HALFWORD:
                taken = (iss.rb[16:31] == '0);
            default:
                taken = 1'b0;
        endcase
        if (taken && !link && iss.op >= spu_odd_pkg::BRANCH_IF_NOT_ZERO_WORD)
            target = aligned;
    end

    always_comb
    begin
        pkt.unit_id = spu_odd_pkg::unit_id_t'(`BRANCH_UNIT_ID);
        pkt.rt_value = '0;
        // return address goes to word 0
        if (link)
            pkt.rt_value[0:`PC_BITS-1] = iss.pc + `PC_BITS'(4);
        pkt.wrt_en = link;
        pkt.rt_addr = iss.rt_addr;
        pkt.latency = spu_odd_pkg::latency_t'(`BRANCH_LATENCY);
    end

    // with a word aligned pc every taken branch lands on a word boundary
    a_target_aligned : assert property (@(iss)
        taken && iss.pc[`PC_BITS-2:`PC_BITS-1] == 2'b00
            |-> target[`PC_BITS-2:`PC_BITS-1] == 2'b00);

endmodule

`default_nettype wire

// File: logic/forward_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module forward_pipe (
    input  wire                           clock,
    input  wire                           reset,
    input  wire spu_odd_pkg::fw_packet_t  stage1,
    output spu_odd_pkg::fw_packet_t       stages [1:`FW_STAGES]
);

    // registered stages only, stage 1 is combinational
    spu_odd_pkg::fw_packet_t pipe_q [2:`FW_STAGES];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int s = 2; s <= `FW_STAGES; s++)
                pipe_q[s] <= '0;
        end
        else
        begin
            pipe_q[2] <= stage1;
            for (int s = 3; s <= `FW_STAGES; s++)
                pipe_q[s] <= pipe_q[s-1];
        end
    end

    always_comb
    begin
        stages[1] = stage1;
        for (int s = 2; s <= `FW_STAGES; s++)
            stages[s] = pipe_q[s];
    end

    // a writing result must tell the consumer when it is ready
    a_latency_set : assert property (@(posedge clock) disable iff (reset)
        stage1.wrt_en |-> stage1.latency != '0);

endmodule

`default_nettype wire

// File: logic/odd_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module odd_pipe (
    input  wire                           clock,
    input  wire                           reset,
    input  wire spu_odd_pkg::opcode_t     op,
    input  wire spu_odd_pkg::quadword_t   ra,
    input  wire spu_odd_pkg::quadword_t   rb,
    input  wire spu_odd_pkg::reg_addr_t   rt_addr,
    input  wire spu_odd_pkg::imm7_t       i7,
    input  wire spu_odd_pkg::imm16_t      i16,
    input  wire spu_odd_pkg::pc_t         pc_in,
    output spu_odd_pkg::fw_packet_t       fw_stages [1:`FW_STAGES],
    output logic                          branch_taken,
    output spu_odd_pkg::pc_t              pc_out
);

    spu_odd_pkg::issue_t     iss;
    spu_odd_pkg::fw_packet_t perm_pkt;
    spu_odd_pkg::fw_packet_t br_pkt;
    spu_odd_pkg::fw_packet_t stage1;
    spu_odd_pkg::pc_t        target;
    logic                    taken;
    logic                    is_permute;
    logic                    is_branch;

    // issue register with the opcode cleared to no-op by reset
    always_ff @(posedge clock)
    begin
        iss.ra <= ra;
        iss.rb <= rb;
        iss.rt_addr <= rt_addr;
        iss.i7 <= i7;
        iss.i16 <= i16;
        iss.pc <= pc_in;
        if (reset)
            iss.op <= spu_odd_pkg::NO_OPERATION;
        else
            iss.op <= op;
    end

    permute_unit u_permute (
        .iss (iss),
        .pkt (perm_pkt)
    );

    branch_unit u_branch (
        .iss    (iss),
        .pkt    (br_pkt),
        .taken  (taken),
        .target (target)
    );

    // unit decode by opcode range
    assign is_permute = iss.op inside {[spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS :
                                        spu_odd_pkg::GATHER_BITS_FROM_WORDS]};
    assign is_branch = iss.op inside {[spu_odd_pkg::BRANCH_RELATIVE :
                                       spu_odd_pkg::BRANCH_IF_ZERO_HALFWORD]};

    always_comb
    begin
        if (is_permute)
            stage1 = perm_pkt;
        else if (is_branch)
            stage1 = br_pkt;
        else
            stage1 = '0;
    end

    // pc redirect straight from the issued branch
    assign branch_taken = is_branch & taken;
    assign pc_out = is_branch ? target : '0;

    forward_pipe u_forward (
        .clock  (clock),
        .reset  (reset),
        .stage1 (stage1),
        .stages (fw_stages)
    );

endmodule

`default_nettype wire

// File: logic/permute_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module permute_unit (
    input  wire spu_odd_pkg::issue_t      iss,
    output spu_odd_pkg::fw_packet_t       pkt
);

    localparam int BYTE     = 8;
    localparam int HALFWORD = 16;
    localparam int WORD     = 32;

    // shift amount in bits, byte shifts reach 31*8
    logic [7:0]             amount;
    logic                   rotate;
    logic                   use_gather;
    logic                   valid;
    spu_odd_pkg::quadword_t gathered;
    spu_odd_pkg::quadword_t shifted;

    // one shifter serves every shift and rotate form
    function automatic spu_odd_pkg::quadword_t shift_left(
        input spu_odd_pkg::quadword_t value,
        input logic [7:0]             count,
        input logic                   wrap
    );
        spu_odd_pkg::quadword_t moved;
        spu_odd_pkg::quadword_t spill;
        moved = value << count;
        // count of zero shifts by the full width and leaves nothing
        spill = value >> (`QUADWORD_BITS - count);
        return wrap ? (moved | spill) : moved;
    endfunction

    always_comb
    begin
        amount = '0;
        rotate = 1'b0;
        use_gather = 1'b0;
        valid = 1'b1;
        gathered = '0;
        case (iss.op)
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS:
                amount = {5'd0, iss.rb[29:31]};
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                amount = {5'd0, iss.i7[4:6]};
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTES:
                amount = {iss.rb[27:31], 3'b000};
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE:
                amount = {iss.i7[2:6], 3'b000};
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
                amount = {iss.rb[24:28], 3'b000};
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES:
            begin
                rotate = 1'b1;
                amount = {1'b0, iss.rb[28:31], 3'b000};
            end
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
            begin
                rotate = 1'b1;
                amount = {1'b0, iss.i7[3:6], 3'b000};
            end
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
            begin
                rotate = 1'b1;
                amount = {1'b0, iss.rb[25:28], 3'b000};
            end
            spu_odd_pkg::ROTATE_QUADWORD_BY_BITS:
            begin
                rotate = 1'b1;
                amount = {5'd0, iss.rb[29:31]};
            end
            spu_odd_pkg::ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
            begin
                rotate = 1'b1;
                amount = {5'd0, iss.i7[4:6]};
            end
            // element 0 lands in the msb of the right-justified field
            spu_odd_pkg::GATHER_BITS_FROM_BYTES:
            begin
                use_gather = 1'b1;
                for (int j = 0; j < 16; j++)
                    gathered[WORD - 16 + j] = iss.ra[j * BYTE + BYTE - 1];
            end
            spu_odd_pkg::GATHER_BITS_FROM_HALFWORDS:
            begin
                use_gather = 1'b1;
                for (int j = 0; j < 8; j++)
                    gathered[WORD - 8 + j] = iss.ra[j * HALFWORD + HALFWORD - 1];
            end
            spu_odd_pkg::GATHER_BITS_FROM_WORDS:
            begin
                use_gather = 1'b1;
                for (int j = 0; j < 4; j++)
                    gathered[WORD - 4 + j] = iss.ra[j * WORD + WORD - 1];
            end
            default:
                valid = 1'b0;
        endcase
    end

    assign shifted = shift_left(iss.ra, amount, rotate);

    always_comb
    begin
        pkt.unit_id = spu_odd_pkg::unit_id_t'(`PERMUTE_UNIT_ID);
        pkt.rt_value = '0;
        if (valid)
            pkt.rt_value = use_gather ? gathered : shifted;
        pkt.wrt_en = valid;
        pkt.rt_addr = iss.rt_addr;
        pkt.latency = spu_odd_pkg::latency_t'(`PERMUTE_LATENCY);
    end

    // the opcode range in the package must agree with the decode above
    a_permute_writes : assert property (@(iss.op)
        iss.op inside {[spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS :
                        spu_odd_pkg::GATHER_BITS_FROM_WORDS]} |-> pkt.wrt_en);

endmodule

`default_nettype wire

// File: logic/spu_odd_defines.svh
`ifndef SPU_ODD_DEFINES_SVH
`define SPU_ODD_DEFINES_SVH

// datapath widths
`define QUADWORD_BITS 128
`define PC_BITS 32
`define REG_ADDR_BITS 7
`define IMM7_BITS 7
`define IMM16_BITS 16

// stage 1 plus six registered stages
`define FW_STAGES 7

// cycles until the result may be forwarded
`define PERMUTE_LATENCY 4
`define BRANCH_LATENCY 1

// unit ids as seen by the forwarding logic
`define PERMUTE_UNIT_ID 5
`define BRANCH_UNIT_ID 7

// packet field widths
`define UNIT_ID_BITS 3
`define LATENCY_BITS 4

`endif

// File: logic/spu_odd_pkg.sv
`default_nettype none

`include "spu_odd_defines.svh"

package spu_odd_pkg;

    // all vectors are big-endian, bit 0 is the msb
    typedef logic [0:`QUADWORD_BITS-1] quadword_t;
    typedef logic [0:`PC_BITS-1]       pc_t;
    typedef logic [0:`REG_ADDR_BITS-1] reg_addr_t;
    typedef logic [0:`IMM7_BITS-1]     imm7_t;
    typedef logic [0:`IMM16_BITS-1]    imm16_t;
    typedef logic [0:`UNIT_ID_BITS-1]  unit_id_t;
    typedef logic [0:`LATENCY_BITS-1]  latency_t;

    // permute opcodes occupy 1 to 13 and branch opcodes 14 to 21,
    // the top level decodes the unit by range
    typedef enum logic [4:0] {
        NO_OPERATION = 5'd0,
        SHIFT_LEFT_QUADWORD_BY_BITS,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES,
        SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        ROTATE_QUADWORD_BY_BYTES,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
        ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        ROTATE_QUADWORD_BY_BITS,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
        GATHER_BITS_FROM_BYTES,
        GATHER_BITS_FROM_HALFWORDS,
        GATHER_BITS_FROM_WORDS,
        BRANCH_RELATIVE,
        BRANCH_ABSOLUTE,
        BRANCH_RELATIVE_AND_SET_LINK,
        BRANCH_ABSOLUTE_AND_SET_LINK,
        BRANCH_IF_NOT_ZERO_WORD,
        BRANCH_IF_ZERO_WORD,
        BRANCH_IF_NOT_ZERO_HALFWORD,
        BRANCH_IF_ZERO_HALFWORD
    } opcode_t;

    // 143 bits, unit id in the top bits
    typedef struct packed {
        unit_id_t  unit_id;
        quadword_t rt_value;
        logic      wrt_en;
        reg_addr_t rt_addr;
        latency_t  latency;
    } fw_packet_t;

    // instruction as held in the issue register
    typedef struct packed {
        opcode_t   op;
        quadword_t ra;
        quadword_t rb;
        reg_addr_t rt_addr;
        imm7_t     i7;
        imm16_t    i16;
        pc_t       pc;
    } issue_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the odd pipeline testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f spu_odd.f --top-module odd_pipe_tb -o odd_pipe_sim \
    && ./obj_dir/odd_pipe_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see sim.log"; exit 1; }
grep -qx "sim passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: spu_odd.f
+incdir+logic
logic/spu_odd_pkg.sv
logic/permute_unit.sv
logic/branch_unit.sv
logic/forward_pipe.sv
logic/odd_pipe.sv
verif/odd_pipe_checker.sv
verif/odd_pipe_tb.sv

// File: verif/odd_pipe_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module odd_pipe_checker (
    input  wire                          clock,
    input  wire                          reset,
    input  wire spu_odd_pkg::opcode_t    op,
    input  wire spu_odd_pkg::quadword_t  ra,
    input  wire spu_odd_pkg::quadword_t  rb,
    input  wire spu_odd_pkg::reg_addr_t  rt_addr,
    input  wire spu_odd_pkg::imm7_t      i7,
    input  wire spu_odd_pkg::imm16_t     i16,
    input  wire spu_odd_pkg::pc_t        pc_in,
    input  wire spu_odd_pkg::fw_packet_t fw_stages [1:`FW_STAGES],
    input  wire                          branch_taken,
    input  wire spu_odd_pkg::pc_t        pc_out,
    output int                           check_count,
    output int                           error_count
);

    // expected contents of each stage, stage 1 is the newest
    spu_odd_pkg::fw_packet_t hist [1:`FW_STAGES];
    logic                    exp_taken;
    spu_odd_pkg::pc_t        exp_pc;
    logic                    primed;

    // reference model of the instruction on the inputs at this edge
    function automatic void predict(
        output spu_odd_pkg::fw_packet_t pkt,
        output logic                    taken,
        output spu_odd_pkg::pc_t        target
    );
        logic [31:0] slot;
        logic [31:0] imm;
        logic [31:0] offset;
        logic        wrap;
        logic        link;
        int          n;
        int          size;
        int          sx;
        slot = rb[0:31];
        imm = 32'(i7);
        sx = $signed(i16);
        offset = 32'(sx * 4);
        pkt = '0;
        taken = 1'b0;
        target = '0;
        n = -1;
        size = 0;
        case (op)
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS: n = slot[2:0];
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE: n = imm[2:0];
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTES: n = slot[4:0] * 8;
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE: n = imm[4:0] * 8;
            spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT: n = slot[7:3] * 8;
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES: n = slot[3:0] * 8;
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_IMMEDIATE: n = imm[3:0] * 8;
            spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT: n = slot[6:3] * 8;
            spu_odd_pkg::ROTATE_QUADWORD_BY_BITS: n = slot[2:0];
            spu_odd_pkg::ROTATE_QUADWORD_BY_BITS_IMMEDIATE: n = imm[2:0];
            spu_odd_pkg::GATHER_BITS_FROM_BYTES: size = 8;
            spu_odd_pkg::GATHER_BITS_FROM_HALFWORDS: size = 16;
            spu_odd_pkg::GATHER_BITS_FROM_WORDS: size = 32;
            spu_odd_pkg::BRANCH_RELATIVE,
            spu_odd_pkg::BRANCH_RELATIVE_AND_SET_LINK:
                target = pc_in + offset;
            spu_odd_pkg::BRANCH_ABSOLUTE,
            spu_odd_pkg::BRANCH_ABSOLUTE_AND_SET_LINK:
                target = offset;
            spu_odd_pkg::BRANCH_IF_NOT_ZERO_WORD: taken = (slot != 0);
            spu_odd_pkg::BRANCH_IF_ZERO_WORD: taken = (slot == 0);
            spu_odd_pkg::BRANCH_IF_NOT_ZERO_HALFWORD: taken = (slot[15:0] != 0);
            spu_odd_pkg::BRANCH_IF_ZERO_HALFWORD: taken = (slot[15:0] == 0);
            default: ;
        endcase
        wrap = op inside {spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES,
                          spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
                          spu_odd_pkg::ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
                          spu_odd_pkg::ROTATE_QUADWORD_BY_BITS,
                          spu_odd_pkg::ROTATE_QUADWORD_BY_BITS_IMMEDIATE};
        // result bit i comes from source bit i+n
        for (int i = 0; n >= 0 && i < `QUADWORD_BITS; i++)
            if (wrap || i + n < `QUADWORD_BITS)
                pkt.rt_value[i] = ra[(i + n) % `QUADWORD_BITS];
        for (int j = 0; size > 0 && j < `QUADWORD_BITS / size; j++)
            pkt.rt_value[32 - `QUADWORD_BITS / size + j] = ra[(j + 1) * size - 1];
        if (op >= spu_odd_pkg::SHIFT_LEFT_QUADWORD_BY_BITS
            && op <= spu_odd_pkg::GATHER_BITS_FROM_WORDS)
        begin
            pkt.unit_id = spu_odd_pkg::unit_id_t'(`PERMUTE_UNIT_ID);
            pkt.latency = spu_odd_pkg::latency_t'(`PERMUTE_LATENCY);
            pkt.wrt_en = 1'b1;
        end
        else if (op >= spu_odd_pkg::BRANCH_RELATIVE)
        begin
            link = op inside {spu_odd_pkg::BRANCH_RELATIVE_AND_SET_LINK,
                              spu_odd_pkg::BRANCH_ABSOLUTE_AND_SET_LINK};
            // conditional targets drop the two low bits
            if (op <= spu_odd_pkg::BRANCH_ABSOLUTE_AND_SET_LINK)
                taken = 1'b1;
            else if (taken)
                target = (pc_in + offset) & ~32'd3;
            pkt.unit_id = spu_odd_pkg::unit_id_t'(`BRANCH_UNIT_ID);
            pkt.latency = spu_odd_pkg::latency_t'(`BRANCH_LATENCY);
            pkt.wrt_en = link;
            if (link)
                pkt.rt_value[0:31] = pc_in + 32'd4;
        end
        if (pkt.unit_id != '0)
            pkt.rt_addr = rt_addr;
    endfunction

    task automatic compare(
        input string                                   name,
        input logic [$bits(spu_odd_pkg::fw_packet_t)-1:0] actual,
        input logic [$bits(spu_odd_pkg::fw_packet_t)-1:0] expected
    );
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED %s at %0t: expected %0h, got %0h", name, $time, expected, actual);
        end
    endtask

    initial
    begin
        check_count = 0;
        error_count = 0;
        primed = 1'b0;
    end

    always @(posedge clock)
    begin
        if (reset)
        begin
            for (int s = 1; s <= `FW_STAGES; s++)
                hist[s] = '0;
            exp_taken = 1'b0;
            exp_pc = '0;
        end
        else
        begin
            for (int s = `FW_STAGES; s > 1; s--)
                hist[s] = hist[s-1];
            predict(hist[1], exp_taken, exp_pc);
        end
        primed = 1'b1;
    end

    // outputs are settled by the falling edge
    always @(negedge clock)
    begin
        if (primed)
        begin
            for (int s = 1; s <= `FW_STAGES; s++)
                compare($sformatf("fw_stages[%0d]", s), fw_stages[s], hist[s]);
            compare("branch_taken", branch_taken, exp_taken);
            compare("pc_out", pc_out, exp_pc);
        end
    end

endmodule

`default_nettype wire

// File: verif/odd_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "spu_odd_defines.svh"

module odd_pipe_tb;

    localparam int unsigned SEED = 32'h683d7a33;
    localparam int IDLE_TIMEOUT = 20;

    logic                    clock;
    logic                    reset;
    spu_odd_pkg::opcode_t    op;
    spu_odd_pkg::quadword_t  ra;
    spu_odd_pkg::quadword_t  rb;
    spu_odd_pkg::reg_addr_t  rt_addr;
    spu_odd_pkg::imm7_t      i7;
    spu_odd_pkg::imm16_t     i16;
    spu_odd_pkg::pc_t        pc_in;
    spu_odd_pkg::fw_packet_t fw_stages [1:`FW_STAGES];
    logic                    branch_taken;
    spu_odd_pkg::pc_t        pc_out;
    int                      check_count;
    int                      error_count;
    int                      timeouts = 0;
    int                      failed_tests = 0;

    odd_pipe uut (.*);

    odd_pipe_checker u_checker (.*);

    always #50 clock = ~clock;

    // group 0 is shifts and rotates, 1 gathers, 2 branches and 3 any opcode with no-op
    task automatic drive_random(input int group);
        int unsigned code;
        case (group)
            0: code = 1 + $urandom % 10;
            1: code = 11 + $urandom % 3;
            2: code = 14 + $urandom % 8;
            default: code = $urandom % 22;
        endcase
        @(posedge clock);
        #1;
        op = spu_odd_pkg::opcode_t'(5'(code));
        ra = {$urandom, $urandom, $urandom, $urandom};
        rb = {$urandom, $urandom, $urandom, $urandom};
        // conditional branches see a zero rb half the time
        // and a zero low halfword a quarter of the time
        if (op >= spu_odd_pkg::BRANCH_IF_NOT_ZERO_WORD)
        begin
            if ($urandom % 2 == 0)
                rb = '0;
            else if ($urandom % 2 == 0)
                rb[16:31] = '0;
        end
        rt_addr = spu_odd_pkg::reg_addr_t'($urandom);
        i7 = spu_odd_pkg::imm7_t'($urandom);
        i16 = spu_odd_pkg::imm16_t'($urandom);
        pc_in = $urandom;
    endtask

    // issue no-ops until every stage is empty and no redirect is shown
    task automatic wait_idle(input string what);
        int   cycles;
        logic idle;
        cycles = 0;
        idle = 1'b0;
        while (!idle && cycles < IDLE_TIMEOUT)
        begin
            @(posedge clock);
            #1;
            op = spu_odd_pkg::NO_OPERATION;
            cycles++;
            idle = (branch_taken === 1'b0) && (pc_out === '0);
            for (int s = 1; s <= `FW_STAGES; s++)
                if (fw_stages[s] !== '0)
                    idle = 1'b0;
        end
        if (!idle)
        begin
            timeouts++;
            $display("timeout: pipe still busy %0d cycles after %s", cycles, what);
        end
    endtask

    task automatic run_test(input string name, input int group, input int count);
        int errors_before;
        int timeouts_before;
        errors_before = error_count;
        timeouts_before = timeouts;
        for (int k = 0; k < count; k++)
            drive_random(group);
        wait_idle(name);
        if (error_count != errors_before || timeouts != timeouts_before)
            failed_tests++;
        $display("test %s: %0d instructions, %0d mismatches, %0d timeouts", name, count,
                 error_count - errors_before, timeouts - timeouts_before);
    endtask

    initial
    begin
        clock = 1'b0;
        reset = 1'b1;
        op = spu_odd_pkg::NO_OPERATION;
        ra = '0;
        rb = '0;
        rt_addr = '0;
        i7 = '0;
        i16 = '0;
        pc_in = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        run_test("reset", 0, 0);
        run_test("shifts and rotates", 0, 300);
        run_test("gather", 1, 200);
        run_test("branches", 2, 300);
        run_test("forwarding", 3, 400);
        $display("%0d tests failed, %0d checks, %0d mismatches, %0d timeouts",
                 failed_tests, check_count, error_count, timeouts);
        if (failed_tests == 0 && error_count == 0 && check_count > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
